/* id_pkg.sv */
`default_nettype none

package id_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    typedef enum logic [4:0] {
        RI_BLTZ   = 5'b00000,
        RI_BGEZ   = 5'b00001,
        RI_BLTZAL = 5'b10000,
        RI_BGEZAL = 5'b10001
    } regimm_e;

    typedef enum logic [7:0] {
        ALU_NOP    = 8'h00,
        ALU_AND    = 8'h01, ALU_OR    = 8'h02, ALU_XOR  = 8'h03, ALU_NOR   = 8'h04,
        ALU_ADD    = 8'h05, ALU_ADDU  = 8'h06, ALU_SUB  = 8'h07, ALU_SUBU  = 8'h08,
        ALU_SLT    = 8'h09, ALU_SLTU  = 8'h0a,
        ALU_SLL    = 8'h10, ALU_SRL   = 8'h11, ALU_SRA  = 8'h12,
        ALU_SLLV   = 8'h13, ALU_SRLV  = 8'h14, ALU_SRAV = 8'h15,
        ALU_ANDI   = 8'h21, ALU_ORI   = 8'h22, ALU_XORI = 8'h23,
        ALU_ADDI   = 8'h25, ALU_ADDIU = 8'h26,
        ALU_SLTI   = 8'h29, ALU_SLTIU = 8'h2a, ALU_LUI  = 8'h2f,
        ALU_LB     = 8'h40, ALU_LBU   = 8'h41, ALU_LH   = 8'h42, ALU_LHU   = 8'h43,
        ALU_LW     = 8'h44, ALU_SB    = 8'h48, ALU_SH   = 8'h49, ALU_SW    = 8'h4a,
        ALU_BEQ    = 8'h60, ALU_BNE   = 8'h61, ALU_BGTZ = 8'h62, ALU_BLEZ  = 8'h63,
        ALU_BGEZ   = 8'h64, ALU_BLTZ  = 8'h65,
        ALU_BGEZAL = 8'h66, ALU_BLTZAL = 8'h67,
        ALU_J      = 8'h70, ALU_JAL   = 8'h71, ALU_JR   = 8'h72, ALU_JALR  = 8'h73
    } alu_op_e;

    typedef enum logic [3:0] {
        NONE     = 4'd0,
        EQ       = 4'd1,
        NE       = 4'd2,
        GTZ      = 4'd3,
        LEZ      = 4'd4,
        GEZ      = 4'd5,
        LTZ      = 4'd6,
        JUMP_IMM = 4'd7,
        JUMP_REG = 4'd8
    } branch_kind_e;

    typedef struct packed {
        opcode_e    op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e     op;
        logic [25:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic      we;
        reg_addr_t dest;
        word_t     data;
    } fwd_src_t;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         dest_rt;      // Write rt instead of rd.
        logic         reg_we;
        logic         mem_read;
        logic         mem_write;
        logic         link;         // Write the return address.
        branch_kind_e branch_kind;
        logic         valid_instr;
    } id_ctrl_t;

    typedef struct packed {
        word_t     pc;
        word_t     instr;
        word_t     rs_data;
        word_t     rt_data;
        alu_op_e   alu_op;
        reg_addr_t dest;
        logic      reg_we;
        logic      mem_read;
        logic      mem_write;
        word_t     return_addr;
        logic      branch_en;
        word_t     branch_target;
        logic      invalid_instr;
    } id_ex_t;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_decoder import id_pkg::*; (
    input  instr_u   instr_i,
    output id_ctrl_t ctrl_o,
    output logic     rs_re_o,
    output logic     rt_re_o
);

    function automatic alu_op_e special_alu(funct_e f);
        case (f)
            FN_SLL:  return ALU_SLL;
            FN_SRL:  return ALU_SRL;
            FN_SRA:  return ALU_SRA;
            FN_SLLV: return ALU_SLLV;
            FN_SRLV: return ALU_SRLV;
            FN_SRAV: return ALU_SRAV;
            FN_ADD:  return ALU_ADD;
            FN_ADDU: return ALU_ADDU;
            FN_SUB:  return ALU_SUB;
            FN_SUBU: return ALU_SUBU;
            FN_AND:  return ALU_AND;
            FN_OR:   return ALU_OR;
            FN_XOR:  return ALU_XOR;
            FN_NOR:  return ALU_NOR;
            FN_SLT:  return ALU_SLT;
            FN_SLTU: return ALU_SLTU;
            default: return ALU_NOP;
        endcase
    endfunction

    function automatic alu_op_e primary_alu(opcode_e o);
        case (o)
            OP_J:     return ALU_J;
            OP_JAL:   return ALU_JAL;
            OP_BEQ:   return ALU_BEQ;
            OP_BNE:   return ALU_BNE;
            OP_BLEZ:  return ALU_BLEZ;
            OP_BGTZ:  return ALU_BGTZ;
            OP_ADDI:  return ALU_ADDI;
            OP_ADDIU: return ALU_ADDIU;
            OP_SLTI:  return ALU_SLTI;
            OP_SLTIU: return ALU_SLTIU;
            OP_ANDI:  return ALU_ANDI;
            OP_ORI:   return ALU_ORI;
            OP_XORI:  return ALU_XORI;
            OP_LUI:   return ALU_LUI;
            OP_LB:    return ALU_LB;
            OP_LH:    return ALU_LH;
            OP_LW:    return ALU_LW;
            OP_LBU:   return ALU_LBU;
            OP_LHU:   return ALU_LHU;
            OP_SB:    return ALU_SB;
            OP_SH:    return ALU_SH;
            OP_SW:    return ALU_SW;
            default:  return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        ctrl_o        = '0;
        ctrl_o.alu_op = primary_alu(instr_i.r_fmt.op);  // SPECIAL and REGIMM map to NOP here.
        rs_re_o       = 1'b0;
        rt_re_o       = 1'b0;
        case (instr_i.r_fmt.op)
            OP_SPECIAL: begin
                case (instr_i.r_fmt.funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        if (instr_i.r_fmt.rs == '0) begin
                            ctrl_o.alu_op      = special_alu(instr_i.r_fmt.funct);
                            ctrl_o.reg_we      = 1'b1;
                            ctrl_o.valid_instr = 1'b1;
                            rt_re_o            = 1'b1;
                        end
                    end
                    FN_SLLV, FN_SRLV, FN_SRAV, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU: begin
                        ctrl_o.alu_op      = special_alu(instr_i.r_fmt.funct);
                        ctrl_o.reg_we      = 1'b1;
                        ctrl_o.valid_instr = 1'b1;
                        rs_re_o            = 1'b1;
                        rt_re_o            = 1'b1;
                    end
                    FN_JR: begin
                        if (instr_i.r_fmt.rt == '0 && instr_i.r_fmt.rd == '0) begin
                            ctrl_o.alu_op      = ALU_JR;
                            ctrl_o.branch_kind = JUMP_REG;
                            ctrl_o.valid_instr = 1'b1;
                            rs_re_o            = 1'b1;
                        end
                    end
                    FN_JALR: begin
                        if (instr_i.r_fmt.rt == '0) begin
                            ctrl_o.alu_op      = ALU_JALR;
                            ctrl_o.branch_kind = JUMP_REG;
                            ctrl_o.reg_we      = 1'b1;
                            ctrl_o.link        = 1'b1;
                            ctrl_o.valid_instr = 1'b1;
                            rs_re_o            = 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                case (regimm_e'(instr_i.i_fmt.rt))
                    RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL: begin
                        ctrl_o.branch_kind = instr_i.i_fmt.rt[0] ? GEZ : LTZ;
                        ctrl_o.link        = instr_i.i_fmt.rt[4];  // Bit 4 marks the -AL forms.
                        ctrl_o.reg_we      = instr_i.i_fmt.rt[4];
                        ctrl_o.valid_instr = 1'b1;
                        rs_re_o            = 1'b1;
                        case ({instr_i.i_fmt.rt[4], instr_i.i_fmt.rt[0]})
                            2'b00:   ctrl_o.alu_op = ALU_BLTZ;
                            2'b01:   ctrl_o.alu_op = ALU_BGEZ;
                            2'b10:   ctrl_o.alu_op = ALU_BLTZAL;
                            default: ctrl_o.alu_op = ALU_BGEZAL;
                        endcase
                    end
                    default: ;
                endcase
            end
            OP_J: begin
                ctrl_o.branch_kind = JUMP_IMM;
                ctrl_o.valid_instr = 1'b1;
            end
            OP_JAL: begin
                ctrl_o.branch_kind = JUMP_IMM;
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.link        = 1'b1;
                ctrl_o.valid_instr = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl_o.branch_kind = (instr_i.r_fmt.op == OP_BEQ) ? EQ : NE;
                ctrl_o.valid_instr = 1'b1;
                rs_re_o            = 1'b1;
                rt_re_o            = 1'b1;
            end
            OP_BLEZ, OP_BGTZ: begin
                ctrl_o.branch_kind = (instr_i.r_fmt.op == OP_BLEZ) ? LEZ : GTZ;
                ctrl_o.valid_instr = 1'b1;
                rs_re_o            = 1'b1;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                ctrl_o.dest_rt     = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.valid_instr = 1'b1;
                rs_re_o            = (instr_i.r_fmt.op != OP_LUI);
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
                ctrl_o.dest_rt     = 1'b1;
                ctrl_o.reg_we      = 1'b1;
                ctrl_o.mem_read    = 1'b1;
                ctrl_o.valid_instr = 1'b1;
                rs_re_o            = 1'b1;
            end
            OP_SB, OP_SH, OP_SW: begin
                ctrl_o.mem_write   = 1'b1;
                ctrl_o.valid_instr = 1'b1;
                rs_re_o            = 1'b1;
                rt_re_o            = 1'b1;
            end
            default: ;
        endcase

        // Execute only writes the return address through a register write.
        assert (!ctrl_o.link || ctrl_o.reg_we)
            else $error("link set without reg_we");
    end

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit import id_pkg::*; (
    input  reg_addr_t rs_idx_i,
    input  reg_addr_t rt_idx_i,
    input  logic      rs_re_i,
    input  logic      rt_re_i,
    input  word_t     rs_rdata_i,
    input  word_t     rt_rdata_i,
    input  fwd_src_t  ex_fwd_i,
    input  fwd_src_t  mem_fwd_i,
    input  logic      ex_load_i,
    input  reg_addr_t ex_dest_i,
    output word_t     rs_data_o,
    output word_t     rt_data_o,
    output logic      stall_o
);

    // The youngest result wins, so EX is checked before MEM.
    function automatic word_t pick_operand(logic re, reg_addr_t idx, word_t rdata,
                                           fwd_src_t ex, fwd_src_t mem);
        if (!re) begin
            return '0;
        end
        if (ex.we && ex.dest == idx) begin
            return ex.data;
        end
        if (mem.we && mem.dest == idx) begin
            return mem.data;
        end
        return rdata;
    endfunction

    always_comb begin
        rs_data_o = pick_operand(rs_re_i, rs_idx_i, rs_rdata_i, ex_fwd_i, mem_fwd_i);
        rt_data_o = pick_operand(rt_re_i, rt_idx_i, rt_rdata_i, ex_fwd_i, mem_fwd_i);
        stall_o   = ex_load_i && ((rs_re_i && ex_dest_i == rs_idx_i) ||
                                  (rt_re_i && ex_dest_i == rt_idx_i));  // Load data is not ready yet.
    end

endmodule

`default_nettype wire

/* branch_resolve.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_resolve import id_pkg::*; (
    input  branch_kind_e kind_i,
    input  word_t        pc_i,
    input  instr_u       instr_i,
    input  word_t        rs_data_i,
    input  word_t        rt_data_i,
    output logic         branch_en_o,
    output word_t        target_o,
    output word_t        return_addr_o
);

    word_t pc_plus4;
    word_t br_offset;
    logic  taken;

    assign pc_plus4      = pc_i + 32'd4;
    assign br_offset     = {{14{instr_i.i_fmt.imm[15]}}, instr_i.i_fmt.imm, 2'b00};
    assign return_addr_o = pc_i + 32'd8;  // Skips the delay slot.

    always_comb begin
        case (kind_i)
            EQ:       taken = (rs_data_i == rt_data_i);
            NE:       taken = (rs_data_i != rt_data_i);
            GTZ:      taken = ($signed(rs_data_i) > 0);
            LEZ:      taken = ($signed(rs_data_i) <= 0);
            GEZ:      taken = !rs_data_i[WORD_W-1];
            LTZ:      taken = rs_data_i[WORD_W-1];
            JUMP_IMM: taken = 1'b1;
            JUMP_REG: taken = 1'b1;
            default:  taken = 1'b0;
        endcase

        target_o = '0;
        if (taken) begin
            case (kind_i)
                JUMP_IMM: target_o = {pc_plus4[31:28], instr_i.j_fmt.target, 2'b00};
                JUMP_REG: target_o = rs_data_i;
                default:  target_o = pc_plus4 + br_offset;
            endcase
        end
        branch_en_o = taken;
    end

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      instr_valid_i,
    input  word_t     pc_i,
    input  instr_u    instr_i,
    input  word_t     rs_rdata_i,
    input  word_t     rt_rdata_i,
    input  fwd_src_t  ex_fwd_i,
    input  fwd_src_t  mem_fwd_i,
    input  logic      ex_load_i,
    input  reg_addr_t ex_dest_i,
    output logic      stall_o,
    output id_ex_t    id_ex_o,
    output logic      id_ex_valid_o
);

    id_ctrl_t  ctrl;
    logic      rs_re;
    logic      rt_re;
    word_t     rs_data;
    word_t     rt_data;
    logic      hz_stall;
    logic      branch_en;
    word_t     branch_target;
    word_t     return_addr;
    reg_addr_t dest;
    logic      accept;
    id_ex_t    id_ex_d;

    instr_decoder u_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .rs_re_o (rs_re),
        .rt_re_o (rt_re)
    );

    hazard_unit u_hazard (
        .rs_idx_i   (instr_i.r_fmt.rs),
        .rt_idx_i   (instr_i.r_fmt.rt),
        .rs_re_i    (rs_re),
        .rt_re_i    (rt_re),
        .rs_rdata_i (rs_rdata_i),
        .rt_rdata_i (rt_rdata_i),
        .ex_fwd_i   (ex_fwd_i),
        .mem_fwd_i  (mem_fwd_i),
        .ex_load_i  (ex_load_i),
        .ex_dest_i  (ex_dest_i),
        .rs_data_o  (rs_data),
        .rt_data_o  (rt_data),
        .stall_o    (hz_stall)
    );

    branch_resolve u_branch (
        .kind_i        (ctrl.branch_kind),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .rs_data_i     (rs_data),
        .rt_data_i     (rt_data),
        .branch_en_o   (branch_en),
        .target_o      (branch_target),
        .return_addr_o (return_addr)
    );

    assign stall_o = instr_valid_i && hz_stall;
    assign accept  = instr_valid_i && !hz_stall;

    // JAL and the -AL branches link through r31, JALR uses rd.
    always_comb begin
        if (ctrl.link && ctrl.branch_kind != JUMP_REG) begin
            dest = 5'd31;
        end else begin
            dest = ctrl.dest_rt ? instr_i.r_fmt.rt : instr_i.r_fmt.rd;
        end
    end

    always_comb begin
        id_ex_d.pc            = pc_i;
        id_ex_d.instr         = instr_i;
        id_ex_d.rs_data       = rs_data;
        id_ex_d.rt_data       = rt_data;
        id_ex_d.alu_op        = ctrl.alu_op;
        id_ex_d.dest          = dest;
        id_ex_d.reg_we        = ctrl.reg_we;
        id_ex_d.mem_read      = ctrl.mem_read;
        id_ex_d.mem_write     = ctrl.mem_write;
        id_ex_d.return_addr   = ctrl.link ? return_addr : '0;
        id_ex_d.branch_en     = branch_en;
        id_ex_d.branch_target = branch_target;
        id_ex_d.invalid_instr = !ctrl.valid_instr;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o       <= '0;
            id_ex_valid_o <= 1'b0;
        end else begin
            id_ex_valid_o <= accept;
            id_ex_o       <= accept ? id_ex_d : '0;  // A bubble carries an empty bundle.
        end
    end

    a_stall_bubble: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        instr_valid_i && stall_o |=> !id_ex_valid_o)
        else $error("stalled strobe reached the ID/EX register");

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;  // Half of the 4 ns period.
    end

endmodule

`default_nettype wire

/* id_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module id_checker import id_pkg::*; (
    input  logic   clk_i,
    input  logic   active_i,
    input  int     idx_i,
    input  logic   exp_stall_i,
    input  logic   exp_valid_i,
    input  id_ex_t exp_bundle_i,
    input  logic   stall_i,
    input  id_ex_t id_ex_i,
    input  logic   id_ex_valid_i,
    output int     err_count_o,
    output int     tests_done_o
);

    int     err_count      = 0;
    int     tests_done     = 0;
    logic   held_active    = 1'b0;
    int     held_idx       = 0;
    logic   held_valid     = 1'b0;
    logic   held_stall_bad = 1'b0;
    id_ex_t held_bundle    = '0;
    logic   test_bad       = 1'b0;

    assign err_count_o  = err_count;
    assign tests_done_o = tests_done;

    // Outputs are sampled on the falling edge, half a cycle after the inputs change.
    always @(negedge clk_i) begin
        if (held_active) begin
            test_bad = held_stall_bad;
            if (id_ex_valid_i !== held_valid) begin
                $display("ERR %0t: test %0d id_ex_valid_o is %b, expected %b",
                         $time, held_idx, id_ex_valid_i, held_valid);
                err_count = err_count + 1;
                test_bad  = 1'b1;
            end
            if (id_ex_i !== held_bundle) begin
                $display("ERR %0t: test %0d id_ex_o is %h, expected %h",
                         $time, held_idx, id_ex_i, held_bundle);
                err_count = err_count + 1;
                test_bad  = 1'b1;
            end
            $display("test %0d: %s", held_idx, test_bad ? "FAIL" : "pass");
            tests_done = tests_done + 1;
        end else if (id_ex_valid_i !== 1'b0 || id_ex_i !== '0) begin
            $display("ERR %0t: id_ex_o is not empty while no instruction was accepted", $time);
            err_count = err_count + 1;
        end

        held_active    = active_i;  // The registered result shows up one cycle later.
        held_idx       = idx_i;
        held_valid     = exp_valid_i;
        held_bundle    = exp_bundle_i;
        held_stall_bad = (stall_i !== (active_i && exp_stall_i));
        if (held_stall_bad) begin
            $display("ERR %0t: test %0d stall_o is %b, expected %b",
                     $time, idx_i, stall_i, active_i && exp_stall_i);
            err_count = err_count + 1;
        end
    end

endmodule

`default_nettype wire

/* tb_id_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    localparam int NUM_VEC       = 18;
    localparam int WORDS_PER_VEC = 16;  // Nine stimulus words and seven expected words.
    localparam int CYCLE_LIMIT   = 10 * NUM_VEC + 50;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    word_t     pc;
    instr_u    instr;
    word_t     rs_rdata;
    word_t     rt_rdata;
    fwd_src_t  ex_fwd;
    fwd_src_t  mem_fwd;
    logic      ex_load;
    reg_addr_t ex_dest;
    logic      stall;
    id_ex_t    id_ex;
    logic      id_ex_valid;

    logic      exp_active;
    int        exp_idx;
    logic      exp_stall;
    logic      exp_valid;
    id_ex_t    exp_bundle;

    int        err_count;
    int        tests_done;
    int        cycle_cnt = 0;
    int        seed      = 75;
    word_t     vec_mem [0:NUM_VEC*WORDS_PER_VEC-1];

    tb_clk_gen u_clk_gen (
        .clk_o (clk)
    );

    id_stage u_id_stage (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .pc_i          (pc),
        .instr_i       (instr),
        .rs_rdata_i    (rs_rdata),
        .rt_rdata_i    (rt_rdata),
        .ex_fwd_i      (ex_fwd),
        .mem_fwd_i     (mem_fwd),
        .ex_load_i     (ex_load),
        .ex_dest_i     (ex_dest),
        .stall_o       (stall),
        .id_ex_o       (id_ex),
        .id_ex_valid_o (id_ex_valid)
    );

    id_checker u_checker (
        .clk_i         (clk),
        .active_i      (exp_active),
        .idx_i         (exp_idx),
        .exp_stall_i   (exp_stall),
        .exp_valid_i   (exp_valid),
        .exp_bundle_i  (exp_bundle),
        .stall_i       (stall),
        .id_ex_i       (id_ex),
        .id_ex_valid_i (id_ex_valid),
        .err_count_o   (err_count),
        .tests_done_o  (tests_done)
    );

    task automatic apply_vector(input int v);
        int          b;
        logic [31:0] flags;
        id_ex_t      e;
        b     = v * WORDS_PER_VEC;
        flags = vec_mem[b+9];
        e     = '0;  // A stalled strobe leaves an empty bundle.
        if (flags[5]) begin
            e.pc            = vec_mem[b];
            e.instr         = vec_mem[b+1];
            e.alu_op        = alu_op_e'(vec_mem[b+10][7:0]);
            e.dest          = vec_mem[b+11][4:0];
            e.rs_data       = vec_mem[b+12];
            e.rt_data       = vec_mem[b+13];
            e.branch_target = vec_mem[b+14];
            e.return_addr   = vec_mem[b+15];
            e.reg_we        = flags[4];
            e.mem_read      = flags[3];
            e.mem_write     = flags[2];
            e.branch_en     = flags[1];
            e.invalid_instr = flags[0];
        end
        instr_valid <= 1'b1;
        pc          <= vec_mem[b];
        instr       <= vec_mem[b+1];
        rs_rdata    <= vec_mem[b+2];
        rt_rdata    <= vec_mem[b+3];
        ex_fwd      <= {vec_mem[b+4][5:0], vec_mem[b+5]};
        mem_fwd     <= {vec_mem[b+6][5:0], vec_mem[b+7]};
        ex_load     <= vec_mem[b+8][5];
        ex_dest     <= vec_mem[b+8][4:0];
        exp_active  <= 1'b1;
        exp_idx     <= v;
        exp_stall   <= flags[6];
        exp_valid   <= flags[5];
        exp_bundle  <= e;
    endtask

    task automatic apply_idle();
        word_t r0;
        word_t r1;
        r0 = $random(seed);
        r1 = $random(seed);
        instr_valid <= 1'b0;  // Busy buses must not leak into ID/EX.
        pc          <= r0;
        instr       <= r1;
        rs_rdata    <= r0 ^ r1;
        rt_rdata    <= r0 + r1;
        ex_fwd      <= {r1[5:0], r0};
        mem_fwd     <= {r0[5:0], r1};
        ex_load     <= r0[7];
        ex_dest     <= r1[12:8];
        exp_active  <= 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        int v;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        pc          = '0;
        instr       = '0;
        rs_rdata    = '0;
        rt_rdata    = '0;
        ex_fwd      = '0;
        mem_fwd     = '0;
        ex_load     = 1'b0;
        ex_dest     = '0;
        exp_active  = 1'b0;
        exp_idx     = 0;
        exp_stall   = 1'b0;
        exp_valid   = 1'b0;
        exp_bundle  = '0;
        $readmemh("id_vectors.txt", vec_mem);
        if (vec_mem[(NUM_VEC-1)*WORDS_PER_VEC] == '0) begin
            $display("Could not read all %0d vectors from id_vectors.txt.", NUM_VEC);
            $display("Done: errors found");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            rst_n <= 1'b1;
            for (v = 0; v < NUM_VEC; v++) begin
                @(posedge clk);
                apply_vector(v);
                @(posedge clk);
                apply_idle();
            end
            wait (tests_done == NUM_VEC);
            $display("%0d tests run, %0d errors", tests_done, err_count);
            if (err_count == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
id_pkg.sv
instr_decoder.sv
hazard_unit.sv
branch_resolve.sv
id_stage.sv
tb_clk_gen.sv
id_checker.sv
tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= tb_id_stage
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* id_vectors.txt */
// Stimulus: pc instr rs_rdata rt_rdata ex{we,dest} ex_data mem{we,dest} mem_data ld{load,dest}
// Expected: flags{stall,valid,we,mrd,mwr,br,inv} alu_op dest rs_data rt_data target return
00400000 00221821 00000011 00000022 00 00000000 00 00000000 00
30 06 03 00000011 00000022 00000000 00000000
00400004 24850010 00000100 deadbeef 00 00000000 00 00000000 25
30 26 05 00000100 00000000 00000000 00000000
00400008 8ce60008 00001000 12345678 00 00000000 00 00000000 00
38 44 06 00001000 00000000 00000000 00000000
0040000c ad090004 00002000 0000abcd 00 00000000 00 00000000 00
24 4a 00 00002000 0000abcd 00000000 00000000
00400010 00221821 00000011 00000022 21 aaaa0001 21 bbbb0001 00
30 06 03 aaaa0001 00000022 00000000 00000000
00400014 00221821 00000011 00000022 00 00000000 00 00000000 22
40 00 00 00000000 00000000 00000000 00000000
00400014 00221821 00000011 00000022 00 00000000 22 77777777 00
30 06 03 00000011 77777777 00000000 00000000
00400100 1022fffc 00000005 00000005 00 00000000 00 00000000 00
22 60 1f 00000005 00000005 004000f4 00000000
00400104 14220008 00000005 00000005 00 00000000 00 00000000 00
20 61 00 00000005 00000005 00000000 00000000
00400200 1c200010 00000001 00000099 00 00000000 00 00000000 00
22 62 00 00000001 00000000 00400244 00000000
00400204 18200010 00000001 00000099 00 00000000 00 00000000 00
20 63 00 00000001 00000000 00000000 00000000
00400300 04900020 80000000 00000042 00 00000000 00 00000000 00
32 67 1f 80000000 00000000 00400384 00400308
00400304 04810020 80000000 00000042 00 00000000 00 00000000 00
20 64 00 80000000 00000000 00000000 00000000
10400000 08100040 00000123 00000456 00 00000000 00 00000000 00
22 70 00 00000000 00000000 10400100 00000000
00400400 0c000100 00000000 00000000 00 00000000 00 00000000 00
32 71 1f 00000000 00000000 00000400 00400408
00400500 00a01009 11111111 00000000 25 00400800 00 00000000 00
32 73 02 00400800 00000000 00400800 00400508
00400600 00220018 00000011 00000022 00 00000000 00 00000000 00
21 00 00 00000000 00000000 00000000 00000000
00400604 fc221800 00000011 00000022 00 00000000 00 00000000 00
21 00 03 00000000 00000000 00000000 00000000
